/* Makefile */
# Verilator flow for periph_hub

VERILATOR ?= verilator
FILELIST  ?= periph_hub.f
RTL_TOP   ?= periph_hub
TB_TOP    ?= tb_periph_hub
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --assert $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q -x "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/byte_periph_bank.sv */
/*
 * Simple bank: slot decode from address bits 7:4,
 * four byte registers per slot, always-ready reads
 * and register 0 of each slot as its pin byte
 */

`timescale 1ns/1ps
`include "periph_defs.svh"

module byte_periph_bank (
    input  logic                       clk,
    input  logic                       rst_n,
    input  periph_bus_pkg::addr_t      i_addr,
    input  periph_bus_pkg::data_word_t i_wdata,
    input  periph_bus_pkg::access_t    i_write_n,
    input  periph_bus_pkg::access_t    i_read_n,
    input  logic                       i_read_busy,
    output periph_bus_pkg::data_word_t o_rdata,
    output logic                       o_ready,
    output periph_map_pkg::byte_pins_t o_pins
);
    import periph_bus_pkg::*;

    localparam int SLOT_IW = $clog2(`PH_SIMPLE_SLOTS);
    localparam int REG_IW  = $clog2(`PH_BYTE_REGS);

    logic       bank_hit;
    logic [3:0] slot;
    logic [3:0] reg_idx;
    logic       reg_valid;
    logic [7:0] byte_regs [`PH_SIMPLE_SLOTS][`PH_BYTE_REGS];

    assign bank_hit = i_addr[`PH_ADDR_W-1];
    assign slot     = i_addr[7:4];
    assign reg_idx  = i_addr[3:0];

    // Only slots and offsets that exist take writes or return data
    assign reg_valid = bank_hit && (slot < `PH_SIMPLE_SLOTS) && (reg_idx < `PH_BYTE_REGS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `PH_SIMPLE_SLOTS; s++) begin
                for (int r = 0; r < `PH_BYTE_REGS; r++) begin
                    byte_regs[s][r] <= '0;
                end
            end
        end else if (reg_valid && (i_write_n != ACC_NONE)) begin
            byte_regs[slot[SLOT_IW-1:0]][reg_idx[REG_IW-1:0]] <= i_wdata[7:0];
        end
    end

    always_comb begin
        o_rdata = '0;
        if (reg_valid) begin
            o_rdata[7:0] = byte_regs[slot[SLOT_IW-1:0]][reg_idx[REG_IW-1:0]];
        end
    end

    assign o_ready = bank_hit && (i_read_n != ACC_NONE) && !i_read_busy;

    always_comb begin
        for (int s = 0; s < `PH_SIMPLE_SLOTS; s++) begin
            o_pins[s] = byte_regs[s][0];
        end
    end

endmodule

/* hdl/gpio_ctrl.sv */
/*
 * GPIO slot: output register, input pin readback
 * and the eight per-pin function select registers
 */

`timescale 1ns/1ps
`include "periph_defs.svh"

module gpio_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_sel,
    input  logic [5:0]                    i_ofs,
    input  periph_bus_pkg::data_word_t    i_wdata,
    input  logic                          i_write,
    input  periph_map_pkg::pins_t         i_ui_in,
    output periph_bus_pkg::data_word_t    o_rdata,
    output periph_map_pkg::pins_t         o_gpio_out,
    output periph_map_pkg::func_sel_arr_t o_func_sel
);
    import periph_map_pkg::*;

    pins_t         gpio_out_q;
    func_sel_arr_t func_sel_q;
    logic          wr_en;
    logic          fs_hit;
    logic [2:0]    fs_idx;

    assign wr_en = i_sel && i_write;

    // Select words live at 0x20..0x3c, word aligned
    assign fs_hit = ((i_ofs & 6'h23) == `PH_FUNC_SEL_BASE);
    assign fs_idx = i_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
            for (int i = 0; i < `PH_PIN_W; i++) begin
                func_sel_q[i] <= (i < 2) ? FUNC_SEL_RESET_WORD : FUNC_SEL_RESET_GPIO;
            end
        end else if (wr_en) begin
            if (i_ofs == `PH_GPIO_OUT_OFS) begin
                gpio_out_q <= i_wdata[`PH_PIN_W-1:0];
            end
            if (fs_hit) begin
                func_sel_q[fs_idx] <= i_wdata[4:0];
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_ofs == `PH_GPIO_OUT_OFS) begin
            o_rdata[`PH_PIN_W-1:0] = gpio_out_q;
        end else if (i_ofs == `PH_GPIO_IN_OFS) begin
            o_rdata[`PH_PIN_W-1:0] = i_ui_in;
        end else if (fs_hit) begin
            o_rdata[4:0] = func_sel_q[fs_idx];
        end
    end

    assign o_gpio_out = gpio_out_q;
    assign o_func_sel = func_sel_q;

endmodule

/* hdl/periph_bus_pkg.sv */
/*
 * Core-side bus types: access size code,
 * data word and peripheral address
 */

`include "periph_defs.svh"

package periph_bus_pkg;

    // Access size, same coding for reads and writes
    typedef logic [1:0] access_t;

    localparam access_t ACC_8    = 2'b00;
    localparam access_t ACC_16   = 2'b01;
    localparam access_t ACC_32   = 2'b10;
    localparam access_t ACC_NONE = 2'b11;

    typedef logic [`PH_DATA_W-1:0] data_word_t;
    typedef logic [`PH_ADDR_W-1:0] addr_t;

endpackage

/* hdl/periph_defs.svh */
/*
 * Shared constants of the peripheral hub:
 * bus and pin widths, slot counts of both banks,
 * GPIO register offsets and user slot numbers
 */

`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

`define PH_ADDR_W        11
`define PH_DATA_W        32
`define PH_PIN_W         8

`define PH_USER_SLOTS    4
`define PH_SIMPLE_SLOTS  4
`define PH_BYTE_REGS     4

// Offsets inside the GPIO slot, one word per function select
`define PH_GPIO_OUT_OFS  6'h00
`define PH_GPIO_IN_OFS   6'h04
`define PH_FUNC_SEL_BASE 6'h20

`define PH_SLOT_GPIO     1
`define PH_SLOT_WORD     2

`endif

/* hdl/periph_hub.sv */
/*
 * Peripheral hub top level: user bank, simple bank,
 * read return path and output pin router
 */

`timescale 1ns/1ps

module periph_hub (
    input  logic                       clk,
    input  logic                       rst_n,
    input  periph_bus_pkg::addr_t      i_addr,
    input  periph_bus_pkg::data_word_t i_data,
    input  periph_bus_pkg::access_t    i_write_n,
    input  periph_bus_pkg::access_t    i_read_n,
    input  logic                       i_read_complete,
    input  periph_map_pkg::pins_t      i_ui_in,
    output periph_bus_pkg::data_word_t o_data_out,
    output logic                       o_data_ready,
    output periph_map_pkg::pins_t      o_uo_out
);
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    data_word_t    user_rdata;
    data_word_t    byte_rdata;
    logic          user_ready;
    logic          byte_ready;
    logic          read_busy;
    user_pins_t    user_pins;
    byte_pins_t    byte_pins;
    func_sel_arr_t func_sel;

    user_periph_bank u_user_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_addr      (i_addr),
        .i_wdata     (i_data),
        .i_write_n   (i_write_n),
        .i_read_n    (i_read_n),
        .i_read_busy (read_busy),
        .i_ui_in     (i_ui_in),
        .o_rdata     (user_rdata),
        .o_ready     (user_ready),
        .o_pins      (user_pins),
        .o_func_sel  (func_sel)
    );

    byte_periph_bank u_byte_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_addr      (i_addr),
        .i_wdata     (i_data),
        .i_write_n   (i_write_n),
        .i_read_n    (i_read_n),
        .i_read_busy (read_busy),
        .o_rdata     (byte_rdata),
        .o_ready     (byte_ready),
        .o_pins      (byte_pins)
    );

    read_return u_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_user_rdata    (user_rdata),
        .i_user_ready    (user_ready),
        .i_byte_rdata    (byte_rdata),
        .i_byte_ready    (byte_ready),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready),
        .o_read_busy     (read_busy)
    );

    pin_mux u_pin_mux (
        .i_func_sel  (func_sel),
        .i_user_pins (user_pins),
        .i_byte_pins (byte_pins),
        .o_uo_out    (o_uo_out)
    );

endmodule

/* hdl/periph_map_pkg.sv */
/*
 * Address map and pin routing types:
 * function select code, pin byte, per-bank pin arrays
 * and the function select reset values
 */

`include "periph_defs.svh"

package periph_map_pkg;

    // Bit 4 picks the simple bank, bits 3:0 the slot
    typedef logic [4:0] func_sel_t;
    typedef logic [`PH_PIN_W-1:0] pins_t;

    typedef func_sel_t func_sel_arr_t [`PH_PIN_W];
    typedef pins_t user_pins_t [`PH_USER_SLOTS];
    typedef pins_t byte_pins_t [`PH_SIMPLE_SLOTS];

    // Pins 0 and 1 come up on the word register, the rest on GPIO
    localparam func_sel_t FUNC_SEL_RESET_WORD = 5'(`PH_SLOT_WORD);
    localparam func_sel_t FUNC_SEL_RESET_GPIO = 5'(`PH_SLOT_GPIO);

endpackage

/* hdl/pin_mux.sv */
/*
 * Output pin router: each pin takes its own bit
 * from the slot named by its function select
 */

`timescale 1ns/1ps
`include "periph_defs.svh"

module pin_mux (
    input  periph_map_pkg::func_sel_arr_t i_func_sel,
    input  periph_map_pkg::user_pins_t    i_user_pins,
    input  periph_map_pkg::byte_pins_t    i_byte_pins,
    output periph_map_pkg::pins_t         o_uo_out
);
    import periph_map_pkg::*;

    localparam int USER_IW = $clog2(`PH_USER_SLOTS);
    localparam int BYTE_IW = $clog2(`PH_SIMPLE_SLOTS);

    always_comb begin
        for (int i = 0; i < `PH_PIN_W; i++) begin
            o_uo_out[i] = 1'b0;
            if (i_func_sel[i][4]) begin
                if (i_func_sel[i][3:0] < `PH_SIMPLE_SLOTS) begin
                    o_uo_out[i] = i_byte_pins[i_func_sel[i][BYTE_IW-1:0]][i];
                end
            end else if (i_func_sel[i][3:0] < `PH_USER_SLOTS) begin
                o_uo_out[i] = i_user_pins[i_func_sel[i][USER_IW-1:0]][i];
            end
        end
    end

endmodule

/* hdl/read_return.sv */
/*
 * Read return path: merges both banks' answers,
 * captures and holds read data until the core completes the read,
 * forms data_ready and the read busy mask
 */

`timescale 1ns/1ps

module read_return (
    input  logic                       clk,
    input  logic                       rst_n,
    input  periph_bus_pkg::data_word_t i_user_rdata,
    input  logic                       i_user_ready,
    input  periph_bus_pkg::data_word_t i_byte_rdata,
    input  logic                       i_byte_ready,
    input  periph_bus_pkg::access_t    i_read_n,
    input  periph_bus_pkg::access_t    i_write_n,
    input  logic                       i_read_complete,
    output periph_bus_pkg::data_word_t o_data_out,
    output logic                       o_data_ready,
    output logic                       o_read_busy
);
    import periph_bus_pkg::*;

    data_word_t comb_rdata;
    data_word_t data_q;
    logic       comb_ready;
    logic       read_req;
    logic       capture;
    logic       hold_q;
    logic       ready_q;

    // The bank that is not addressed drives zeros
    assign comb_rdata = i_user_rdata | i_byte_rdata;
    assign comb_ready = i_user_ready | i_byte_ready;
    assign read_req   = (i_read_n != ACC_NONE);
    assign capture    = read_req && comb_ready && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // Stays up while the held result waits for the core
            ready_q <= read_req && !i_read_complete && (comb_ready || hold_q);
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= comb_rdata;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_write_n != ACC_NONE);
    assign o_read_busy  = ready_q;

endmodule

/* hdl/user_periph_bank.sv */
/*
 * User bank: slot decode from address bits 9:6,
 * GPIO and word register slots, read data and ready mux,
 * per-slot pin bytes
 */

`timescale 1ns/1ps
`include "periph_defs.svh"

module user_periph_bank (
    input  logic                          clk,
    input  logic                          rst_n,
    input  periph_bus_pkg::addr_t         i_addr,
    input  periph_bus_pkg::data_word_t    i_wdata,
    input  periph_bus_pkg::access_t       i_write_n,
    input  periph_bus_pkg::access_t       i_read_n,
    input  logic                          i_read_busy,
    input  periph_map_pkg::pins_t         i_ui_in,
    output periph_bus_pkg::data_word_t    o_rdata,
    output logic                          o_ready,
    output periph_map_pkg::user_pins_t    o_pins,
    output periph_map_pkg::func_sel_arr_t o_func_sel
);
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    logic       bank_hit;
    logic [3:0] slot;
    logic       gpio_sel;
    logic       word_sel;
    access_t    rd_n;
    logic       rd_req;
    data_word_t gpio_rdata;
    data_word_t word_rdata;
    logic       word_ready;
    pins_t      gpio_pins;
    pins_t      word_pins;

    assign bank_hit = !i_addr[`PH_ADDR_W-1];
    assign slot     = i_addr[9:6];
    assign gpio_sel = bank_hit && (slot == `PH_SLOT_GPIO);
    assign word_sel = bank_hit && (slot == `PH_SLOT_WORD);

    // No new reads while the return path still holds a result
    assign rd_n   = (bank_hit && !i_read_busy) ? i_read_n : ACC_NONE;
    assign rd_req = (rd_n != ACC_NONE);

    gpio_ctrl u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (gpio_sel),
        .i_ofs      (i_addr[5:0]),
        .i_wdata    (i_wdata),
        .i_write    (i_write_n != ACC_NONE),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_pins),
        .o_func_sel (o_func_sel)
    );

    word_reg_periph u_word (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_sel     (word_sel),
        .i_ofs     (i_addr[5:0]),
        .i_wdata   (i_wdata),
        .i_write_n (i_write_n),
        .i_read_n  (word_sel ? rd_n : ACC_NONE),
        .o_rdata   (word_rdata),
        .o_ready   (word_ready),
        .o_pins    (word_pins)
    );

    // Empty slots answer at once with zero
    always_comb begin
        o_rdata = '0;
        o_ready = 1'b0;
        if (bank_hit) begin
            case (slot)
                `PH_SLOT_GPIO: begin
                    o_rdata = gpio_rdata;
                    o_ready = rd_req;
                end
                `PH_SLOT_WORD: begin
                    o_rdata = word_rdata;
                    o_ready = word_ready;
                end
                default: o_ready = rd_req;
            endcase
        end
    end

    always_comb begin
        for (int s = 0; s < `PH_USER_SLOTS; s++) begin
            o_pins[s] = '0;
        end
        o_pins[`PH_SLOT_GPIO] = gpio_pins;
        o_pins[`PH_SLOT_WORD] = word_pins;
    end

endmodule

/* hdl/word_reg_periph.sv */
/*
 * User slot 2: one 32-bit register at offset 0,
 * written by 8, 16 or 32-bit accesses, read back one cycle later
 */

`timescale 1ns/1ps
`include "periph_defs.svh"

module word_reg_periph (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_sel,
    input  logic [5:0]                 i_ofs,
    input  periph_bus_pkg::data_word_t i_wdata,
    input  periph_bus_pkg::access_t    i_write_n,
    input  periph_bus_pkg::access_t    i_read_n,
    output periph_bus_pkg::data_word_t o_rdata,
    output logic                       o_ready,
    output periph_map_pkg::pins_t      o_pins
);
    import periph_bus_pkg::*;

    data_word_t word_q;
    data_word_t rdata_q;
    logic       ready_q;
    logic       hit;

    assign hit = i_sel && (i_ofs == '0);

    // Narrow writes only touch the low bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (hit) begin
            case (i_write_n)
                ACC_8:   word_q[7:0]  <= i_wdata[7:0];
                ACC_16:  word_q[15:0] <= i_wdata[15:0];
                ACC_32:  word_q       <= i_wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= i_sel && (i_read_n != ACC_NONE);
        end
    end

    // Other offsets answer, but with zero
    always_ff @(posedge clk) begin
        rdata_q <= hit ? word_q : '0;
    end

    assign o_rdata = rdata_q;
    assign o_ready = ready_q;
    assign o_pins  = word_q[`PH_PIN_W-1:0];

endmodule

/* periph_hub.f */
+incdir+hdl
hdl/periph_bus_pkg.sv
hdl/periph_map_pkg.sv
hdl/gpio_ctrl.sv
hdl/word_reg_periph.sv
hdl/user_periph_bank.sv
hdl/byte_periph_bank.sv
hdl/read_return.sv
hdl/pin_mux.sv
hdl/periph_hub.sv
verification/tb_periph_hub.sv

/* verification/tb_periph_hub.sv */
/*
 * Testbench for the peripheral hub: clock and reset,
 * sized bus writes and reads, LFSR stimulus,
 * register reference model with pin routing,
 * concurrent and immediate assertions, cycle limit
 */

`timescale 1ns/1ps
`include "periph_defs.svh"

module tb_periph_hub;
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic       clk = 1'b0;
    logic       rst_n;
    addr_t      i_addr;
    data_word_t i_data;
    access_t    i_write_n;
    access_t    i_read_n;
    logic       i_read_complete;
    pins_t      i_ui_in;
    data_word_t o_data_out;
    logic       o_data_ready;
    pins_t      o_uo_out;

    // Reference model of every register
    logic [7:0]  m_bytes [`PH_SIMPLE_SLOTS][`PH_BYTE_REGS];
    logic [4:0]  m_fs [`PH_PIN_W];
    logic [7:0]  m_gpio;
    logic [31:0] m_word;
    logic [7:0]  exp_pins;
    logic [31:0] exp_read;
    logic [15:0] lfsr_q;
    int          cycle_cnt = 0;

    periph_hub u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .i_ui_in         (i_ui_in),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready),
        .o_uo_out        (o_uo_out)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            end_with_failure();
        end
    end

    task automatic end_with_failure();
        $display("test failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t ns %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic addr_t user_addr(input int slot, input int ofs);
        return {1'b0, 4'(slot), 6'(ofs)};
    endfunction

    function automatic addr_t byte_addr(input int slot, input int idx);
        return {1'b1, 2'b00, 4'(slot), 4'(idx)};
    endfunction

    task automatic reset_model();
        for (int s = 0; s < `PH_SIMPLE_SLOTS; s++) begin
            for (int r = 0; r < `PH_BYTE_REGS; r++) begin
                m_bytes[s][r] = '0;
            end
        end
        for (int p = 0; p < `PH_PIN_W; p++) begin
            m_fs[p] = (p < 2) ? 5'(`PH_SLOT_WORD) : 5'(`PH_SLOT_GPIO);
        end
        m_gpio = '0;
        m_word = '0;
        exp_pins = '0;
    endtask

    // Each pin takes its own bit of the slot its select names
    function automatic logic [7:0] route_pins();
        logic [7:0] p;
        logic [3:0] s;
        p = '0;
        for (int i = 0; i < `PH_PIN_W; i++) begin
            s = m_fs[i][3:0];
            if (m_fs[i][4]) begin
                if (s < `PH_SIMPLE_SLOTS) p[i] = m_bytes[s[1:0]][0][i];
            end else if (s == `PH_SLOT_GPIO) begin
                p[i] = m_gpio[i];
            end else if (s == `PH_SLOT_WORD) begin
                p[i] = m_word[i];
            end
        end
        return p;
    endfunction

    function automatic logic [31:0] model_read(input addr_t addr);
        logic [3:0]  slot;
        logic [5:0]  ofs;
        logic [31:0] v;
        v = '0;
        if (addr[10]) begin
            slot = addr[7:4];
            ofs = {2'b00, addr[3:0]};
            if (slot < `PH_SIMPLE_SLOTS && ofs < `PH_BYTE_REGS) begin
                v[7:0] = m_bytes[slot[1:0]][ofs[1:0]];
            end
        end else begin
            slot = addr[9:6];
            ofs = addr[5:0];
            if (slot == `PH_SLOT_GPIO) begin
                if (ofs == `PH_GPIO_OUT_OFS) v[7:0] = m_gpio;
                else if (ofs == `PH_GPIO_IN_OFS) v[7:0] = i_ui_in;
                else if (ofs >= `PH_FUNC_SEL_BASE && ofs[1:0] == 2'b00) v[4:0] = m_fs[ofs[4:2]];
            end else if (slot == `PH_SLOT_WORD && ofs == 6'h00) begin
                v = m_word;
            end
        end
        return v;
    endfunction

    task automatic model_write(input addr_t addr, input access_t size, input logic [31:0] d);
        logic [3:0] slot;
        logic [5:0] ofs;
        if (addr[10]) begin
            slot = addr[7:4];
            ofs = {2'b00, addr[3:0]};
            if (slot < `PH_SIMPLE_SLOTS && ofs < `PH_BYTE_REGS) begin
                m_bytes[slot[1:0]][ofs[1:0]] = d[7:0];
            end
        end else begin
            slot = addr[9:6];
            ofs = addr[5:0];
            if (slot == `PH_SLOT_GPIO) begin
                if (ofs == `PH_GPIO_OUT_OFS) m_gpio = d[7:0];
                else if (ofs >= `PH_FUNC_SEL_BASE && ofs[1:0] == 2'b00) m_fs[ofs[4:2]] = d[4:0];
            end else if (slot == `PH_SLOT_WORD && ofs == 6'h00) begin
                case (size)
                    ACC_8:   m_word[7:0] = d[7:0];
                    ACC_16:  m_word[15:0] = d[15:0];
                    ACC_32:  m_word = d;
                    default: ;
                endcase
            end
        end
    endtask

    // The register takes the data at the rising edge inside this task
    task automatic do_write(input addr_t addr, input access_t size, input logic [31:0] d);
        @(negedge clk);
        i_addr = addr;
        i_data = d;
        i_write_n = size;
        @(negedge clk);
        i_write_n = ACC_NONE;
        model_write(addr, size, d);
        exp_pins = route_pins();
    endtask

    task automatic wait_ready();
        do begin
            @(negedge clk);
        end while (o_data_ready !== 1'b1);
    endtask

    task automatic finish_read();
        check_value("o_data_out", exp_read, o_data_out);
        i_read_n = ACC_NONE;
        i_read_complete = 1'b1;
        @(negedge clk);
        i_read_complete = 1'b0;
    endtask

    task automatic do_read(input addr_t addr, input access_t size);
        @(negedge clk);
        i_addr = addr;
        i_read_n = size;
        exp_read = model_read(addr);
        wait_ready();
        finish_read();
    endtask

    // Input pins move while the result is held, bit 0 flips every time
    task automatic hold_read();
        @(negedge clk);
        i_addr = user_addr(`PH_SLOT_GPIO, `PH_GPIO_IN_OFS);
        i_read_n = ACC_8;
        exp_read = model_read(i_addr);
        wait_ready();
        repeat (4) begin
            i_ui_in = i_ui_in ^ (8'(next_bits(8)) | 8'h01);
            @(negedge clk);
            check_value("o_data_ready", 32'd1, 32'(o_data_ready));
            check_value("o_data_out", exp_read, o_data_out);
        end
        finish_read();
    endtask

    assert property (@(posedge clk) disable iff (!rst_n)
        (o_data_ready && (i_read_n != ACC_NONE)) |-> (o_data_out == exp_read))
    else begin
        $display("[ERROR] %0t ns o_data_out expected 0x%08h actual 0x%08h",
                 $time, exp_read, $sampled(o_data_out));
        end_with_failure();
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (o_data_ready && (i_read_n != ACC_NONE) && !i_read_complete) |=> o_data_ready)
    else begin
        $display("[ERROR] %0t ns o_data_ready expected 1 actual 0", $time);
        end_with_failure();
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (i_write_n != ACC_NONE) |-> o_data_ready)
    else begin
        $display("[ERROR] %0t ns o_data_ready expected 1 actual 0", $time);
        end_with_failure();
    end

    // Idle bus, nothing to report
    assert property (@(posedge clk) disable iff (!rst_n)
        ((i_write_n == ACC_NONE) && (i_read_n == ACC_NONE) && !i_read_complete)
        |-> !o_data_ready)
    else begin
        $display("[ERROR] %0t ns o_data_ready expected 0 actual 1", $time);
        end_with_failure();
    end

    assert property (@(posedge clk) disable iff (!rst_n) (o_uo_out == exp_pins))
    else begin
        $display("[ERROR] %0t ns o_uo_out expected 0x%02h actual 0x%02h",
                 $time, exp_pins, $sampled(o_uo_out));
        end_with_failure();
    end

    initial begin
        logic [31:0] d;
        logic [2:0]  pick;
        logic [4:0]  sel;
        addr_t       a;
        $timeformat(-9, 0, "", 0);
        lfsr_q = 16'd52;
        rst_n = 1'b0;
        i_addr = '0;
        i_data = '0;
        i_write_n = ACC_NONE;
        i_read_n = ACC_NONE;
        i_read_complete = 1'b0;
        i_ui_in = '0;
        exp_read = '0;
        reset_model();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("o_data_ready", 32'd0, 32'(o_data_ready));
        check_value("o_uo_out", 32'd0, 32'(o_uo_out));

        // GPIO output, input readback
        do_write(user_addr(`PH_SLOT_GPIO, `PH_GPIO_OUT_OFS), ACC_32, next_bits(32));
        check_value("o_uo_out", 32'(exp_pins), 32'(o_uo_out));
        do_read(user_addr(`PH_SLOT_GPIO, `PH_GPIO_OUT_OFS), ACC_32);
        i_ui_in = 8'(next_bits(8));
        do_read(user_addr(`PH_SLOT_GPIO, `PH_GPIO_IN_OFS), ACC_8);

        // Word register with every write size
        do_write(user_addr(`PH_SLOT_WORD, 0), ACC_32, next_bits(32));
        do_read(user_addr(`PH_SLOT_WORD, 0), ACC_32);
        do_write(user_addr(`PH_SLOT_WORD, 0), ACC_8, next_bits(32));
        check_value("o_uo_out", 32'(exp_pins), 32'(o_uo_out));
        do_read(user_addr(`PH_SLOT_WORD, 0), ACC_32);
        do_write(user_addr(`PH_SLOT_WORD, 0), ACC_16, next_bits(32));
        do_read(user_addr(`PH_SLOT_WORD, 0), ACC_16);
        do_write(user_addr(`PH_SLOT_WORD, 0), ACC_32, next_bits(32));
        check_value("o_uo_out", 32'(exp_pins), 32'(o_uo_out));
        do_read(user_addr(`PH_SLOT_WORD, 0), ACC_32);
        do_read(user_addr(`PH_SLOT_WORD, 4), ACC_32);

        // Byte slots, with writes outside them before the readback
        for (int s = 0; s < `PH_SIMPLE_SLOTS; s++) begin
            for (int r = 0; r < `PH_BYTE_REGS; r++) begin
                do_write(byte_addr(s, r), ACC_8, next_bits(32));
            end
        end
        do_write(byte_addr(6, 0), ACC_8, next_bits(32));
        do_write(byte_addr(2, 9), ACC_8, next_bits(32));
        for (int s = 0; s < `PH_SIMPLE_SLOTS; s++) begin
            for (int r = 0; r < `PH_BYTE_REGS; r++) begin
                do_read(byte_addr(s, r), ACC_8);
            end
        end
        do_read(byte_addr(6, 0), ACC_8);
        do_read(byte_addr(2, 9), ACC_8);
        do_read(byte_addr(15, 3), ACC_8);
        do_read(user_addr(0, 0), ACC_32);
        do_read(user_addr(3, 8), ACC_32);

        // Pin routing to byte slots and empty or out-of-range slots
        repeat (3) begin
            for (int p = 0; p < `PH_PIN_W; p++) begin
                pick = 3'(next_bits(3));
                case (pick)
                    3'd4:    sel = 5'h00;
                    3'd5:    sel = 5'h03;
                    3'd6:    sel = 5'h15;
                    3'd7:    sel = 5'h09;
                    default: sel = {3'b100, pick[1:0]};
                endcase
                d = next_bits(27);
                a = user_addr(`PH_SLOT_GPIO, `PH_FUNC_SEL_BASE + 4 * p);
                do_write(a, ACC_32, {d[26:0], sel});
                check_value("o_uo_out", 32'(exp_pins), 32'(o_uo_out));
                do_read(a, ACC_32);
            end
        end

        hold_read();
        do_read(byte_addr(1, 2), ACC_8);

        $display("test passed");
        $finish;
    end

endmodule
